//--- fetch_fabric_macros.svh
`ifndef FETCH_FABRIC_MACROS_SVH
`define FETCH_FABRIC_MACROS_SVH

// Instruction address width, covers the 2048 word program store
`define FETCH_ADDR_W 11

// Width of one instruction word
`define INSTR_W 32

// Entries in each per-core instruction FIFO
`define FIFO_DEPTH 8

// Instruction bit that steers a word to core 1 when set
`define CORE_SEL_BIT 31

// Free FIFO slots kept back for fetches already in the pipeline
// Memory read, arbiter register and the fetch issued on the same edge
`define FETCH_MARGIN 3

`endif

//--- fetch_fabric_pkg.sv
`include "fetch_fabric_macros.svh"

package fetch_fabric_pkg;

    typedef logic [`FETCH_ADDR_W-1:0] fetch_addr_t;    // Word address into instruction memory
    typedef logic [`INSTR_W-1:0]      instr_t;         // One instruction word

    // Loader write into the program store, only meaningful while cpu_en is low
    typedef struct packed {
        logic        we;                               // Write strobe for one word
        fetch_addr_t addr;                             // Target word address
        instr_t      data;                             // Word to store
    } load_req_t;

    // Branch request coming back from a core
    typedef struct packed {
        logic        valid;                            // Single cycle request
        fetch_addr_t target;                           // New fetch address
    } branch_req_t;

    // Result of an instruction memory read
    typedef struct packed {
        logic   valid;                                 // Word belongs to a live fetch
        instr_t instr;                                 // Word read from memory
    } mem_rd_t;

    // Registered arbiter output feeding both FIFOs
    typedef struct packed {
        logic   wr0;                                   // Write strobe for the core 0 FIFO
        logic   wr1;                                   // Write strobe for the core 1 FIFO
        instr_t instr;                                 // Word shared by both FIFO inputs
    } dispatch_t;

endpackage

//--- fetch_pc.sv
`timescale 1ns/10ps

module fetch_pc (
    input  logic                        sys_clk,
    input  logic                        rst_n,
    input  logic                        cpu_en,        // Fetch enable
    input  fetch_fabric_pkg::branch_req_t branch0,     // Branch from core 0
    input  fetch_fabric_pkg::branch_req_t branch1,     // Branch from core 1
    input  logic                        almost_full0,  // Core 0 FIFO has no room for more
    input  logic                        almost_full1,  // Core 1 FIFO has no room for more
    output fetch_fabric_pkg::fetch_addr_t fetch_addr,  // Address of the issued fetch
    output logic                        fetch_en,      // High for one cycle per issued fetch
    output logic                        flush          // Pipeline kill, one cycle after a branch
);

    import fetch_fabric_pkg::*;

    fetch_addr_t pc;                                   // Next address to fetch
    branch_req_t branch_win;                           // Branch that takes effect this cycle
    logic        stall;                                // One of the FIFOs is near full
    logic        issue;                                // Fetch goes out on this edge

    // Core 0 has priority when both cores branch together
    assign branch_win = branch0.valid ? branch0 : branch1;

    // Stall for both cores together so the two streams stay in program order
    assign stall = almost_full0 | almost_full1;

    // During the flush cycle the FIFOs are about to be emptied, so the
    // almost full flags still showing the old fill level are ignored
    assign issue = cpu_en & (flush | ~stall);

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            pc         <= '0;                          // Program starts at word 0
            fetch_addr <= '0;
            fetch_en   <= 1'b0;
            flush      <= 1'b0;
        end else if (branch_win.valid) begin
            pc       <= branch_win.target;             // Branch wins over any stall
            fetch_en <= 1'b0;                          // Nothing is issued while flushing
            flush    <= 1'b1;                          // Kills memory, arbiter and FIFOs next edge
        end else begin
            flush    <= 1'b0;
            fetch_en <= issue;
            if (issue) begin
                fetch_addr <= pc;                      // Present the word address to memory
                pc         <= pc + 1'b1;               // Wraps to 0 after the last word
            end
        end
    end

endmodule

//--- instr_mem.sv
`timescale 1ns/10ps

`include "fetch_fabric_macros.svh"

module instr_mem (
    input  logic                          sys_clk,
    input  logic                          rst_n,
    input  fetch_fabric_pkg::load_req_t   load,        // External loader write port
    input  fetch_fabric_pkg::fetch_addr_t fetch_addr,  // Read address from the PC
    input  logic                          fetch_en,    // Read strobe from the PC
    input  logic                          flush,       // Drops the word being read
    output fetch_fabric_pkg::mem_rd_t     rd           // Word and valid, one cycle after fetch_en
);

    import fetch_fabric_pkg::*;

    localparam int WORDS = 1 << `FETCH_ADDR_W;         // 2048 words

    instr_t mem [WORDS];                               // Program store, contents survive reset
    instr_t rd_word;                                   // Registered read data
    logic   rd_valid;                                  // Registered read valid

    // Loader port, the testbench only drives it while fetching is disabled
    always_ff @(posedge sys_clk) begin
        if (load.we) begin
            mem[load.addr] <= load.data;
        end
    end

    // Read data only moves on a fetch so the last word stays on the bus
    always_ff @(posedge sys_clk) begin
        if (fetch_en) begin
            rd_word <= mem[fetch_addr];
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= fetch_en & ~flush;             // A branch kills the read in flight
        end
    end

    assign rd = '{valid: rd_valid, instr: rd_word};

endmodule

//--- dispatch_arbiter.sv
`timescale 1ns/10ps

`include "fetch_fabric_macros.svh"

module dispatch_arbiter (
    input  logic                      sys_clk,
    input  logic                      rst_n,
    input  fetch_fabric_pkg::mem_rd_t rd,              // Word coming out of memory
    input  logic                      flush,           // Drops the word being steered
    output fetch_fabric_pkg::dispatch_t disp           // FIFO write strobes and shared word
);

    import fetch_fabric_pkg::*;

    logic   wr0_q;                                     // Write to the core 0 FIFO next edge
    logic   wr1_q;                                     // Write to the core 1 FIFO next edge
    instr_t word_q;                                    // Word handed to both FIFOs
    logic   to_core1;                                  // Core select bit of the incoming word

    assign to_core1 = rd.instr[`CORE_SEL_BIT];

    // Strobes carry the control, they are cleared by reset and by a branch
    always_ff @(posedge sys_clk) begin
        if (!rst_n || flush) begin
            wr0_q <= 1'b0;
            wr1_q <= 1'b0;
        end else begin
            wr0_q <= rd.valid & ~to_core1;             // Exactly one strobe per valid word
            wr1_q <= rd.valid & to_core1;
        end
    end

    // The word itself goes through unchanged, select bit included
    always_ff @(posedge sys_clk) begin
        if (rd.valid) begin
            word_q <= rd.instr;
        end
    end

    assign disp = '{wr0: wr0_q, wr1: wr1_q, instr: word_q};

endmodule

//--- instr_fifo.sv
`timescale 1ns/10ps

`include "fetch_fabric_macros.svh"

module instr_fifo (
    input  logic                     sys_clk,
    input  logic                     rst_n,
    input  logic                     wr,               // Write strobe from the arbiter
    input  logic                     rd,               // Level read strobe from the core
    input  logic                     flush,            // Empties the FIFO on the next edge
    input  fetch_fabric_pkg::instr_t wdata,            // Word to store
    output fetch_fabric_pkg::instr_t rdata,            // Head word, valid while not empty
    output logic                     empty,            // Nothing for the core to read
    output logic                     almost_full       // Fewer than FETCH_MARGIN slots left
);

    import fetch_fabric_pkg::*;

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);
    localparam logic [CNT_W:0] AF_LEVEL = (CNT_W + 1)'(`FIFO_DEPTH - `FETCH_MARGIN);

    instr_t           mem [`FIFO_DEPTH];               // Storage, no reset needed
    logic [PTR_W-1:0] wptr;                            // Next slot to write
    logic [PTR_W-1:0] rptr;                            // Slot shown on rdata
    logic [CNT_W-1:0] count;                           // Words held
    logic [CNT_W:0]   fill_ahead;                      // Count including the write in progress
    logic             full;
    logic             push;
    logic             pop;

    assign full = (count == CNT_W'(`FIFO_DEPTH));
    assign push = wr & ~full & ~flush;                 // Fetch margin keeps full from being hit
    assign pop  = rd & ~empty;                         // A pop on an empty FIFO is ignored

    // Empty already during the flush cycle so a core never reads a stale word
    assign empty = (count == '0) | flush;

    // Show-ahead read, the head word sits on rdata without a pop
    assign rdata = mem[rptr];

    // The write on this edge is counted so the margin covers only the
    // words still in memory and in the PC
    assign fill_ahead  = {1'b0, count} + {{CNT_W{1'b0}}, wr};
    assign almost_full = fill_ahead > AF_LEVEL;

    always_ff @(posedge sys_clk) begin
        if (push) begin
            mem[wptr] <= wdata;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n || flush) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wptr <= wptr + 1'b1;                   // Depth is a power of two, pointer wraps
            end
            if (pop) begin
                rptr <= rptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;               // Both or neither leave the level alone
            endcase
        end
    end

endmodule

//--- fetch_fabric.sv
`timescale 1ns/10ps

module fetch_fabric (
    input  logic                          sys_clk,
    input  logic                          rst_n,
    input  logic                          cpu_en,      // Fetch enable, low while loading
    input  fetch_fabric_pkg::load_req_t   load,        // Program loader write
    input  fetch_fabric_pkg::branch_req_t branch0,     // Branch from core 0
    input  fetch_fabric_pkg::branch_req_t branch1,     // Branch from core 1
    input  logic                          rd0,         // Core 0 read strobe
    input  logic                          rd1,         // Core 1 read strobe
    output fetch_fabric_pkg::instr_t      instr0,      // Core 0 head instruction
    output fetch_fabric_pkg::instr_t      instr1,      // Core 1 head instruction
    output logic                          empty0,      // Core 0 has nothing to read
    output logic                          empty1       // Core 1 has nothing to read
);

    import fetch_fabric_pkg::*;

    fetch_addr_t fetch_addr;                           // PC to memory read address
    logic        fetch_en;                             // PC to memory read strobe
    logic        flush;                                // Branch kill to every stage
    mem_rd_t     mem_rd;                               // Memory to arbiter
    dispatch_t   disp;                                 // Arbiter to both FIFOs
    logic        almost_full0;                         // Core 0 FIFO back-pressure
    logic        almost_full1;                         // Core 1 FIFO back-pressure

    fetch_pc fetch_pc_inst (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .cpu_en       (cpu_en),
        .branch0      (branch0),
        .branch1      (branch1),
        .almost_full0 (almost_full0),
        .almost_full1 (almost_full1),
        .fetch_addr   (fetch_addr),
        .fetch_en     (fetch_en),
        .flush        (flush)
    );

    instr_mem instr_mem_inst (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .load       (load),
        .fetch_addr (fetch_addr),
        .fetch_en   (fetch_en),
        .flush      (flush),
        .rd         (mem_rd)
    );

    dispatch_arbiter dispatch_arbiter_inst (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .rd      (mem_rd),
        .flush   (flush),
        .disp    (disp)
    );

    // Both FIFOs see the same word, only the strobe decides who keeps it
    instr_fifo core0_fifo (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .wr          (disp.wr0),
        .rd          (rd0),
        .flush       (flush),
        .wdata       (disp.instr),
        .rdata       (instr0),
        .empty       (empty0),
        .almost_full (almost_full0)
    );

    instr_fifo core1_fifo (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .wr          (disp.wr1),
        .rd          (rd1),
        .flush       (flush),
        .wdata       (disp.instr),
        .rdata       (instr1),
        .empty       (empty1),
        .almost_full (almost_full1)
    );

endmodule

//--- fetch_fabric_tb.sv
`timescale 1ns/10ps

`include "fetch_fabric_macros.svh"

module fetch_fabric_tb;

    import fetch_fabric_pkg::*;

    localparam int RESET_CYCLES  = 16;
    localparam int MEM_WORDS     = 1 << `FETCH_ADDR_W;     // Whole program store is loaded
    localparam int GOLD_WORDS    = 'h80;                   // Word slots in the golden file
    localparam int IMG_BASE      = 'h10;                   // Program image section
    localparam int C0_BASE       = 'h30;                   // Expected core 0 stream
    localparam int C1_BASE       = 'h50;                   // Expected core 1 stream
    localparam int BR_BASE       = 'h70;                   // Branch scenario records
    localparam int IMG_MAX       = 32;
    localparam int BR_MAX        = 4;
    localparam int BR_WORDS      = 10;                     // Words checked per core after a branch
    localparam int IDLE_CYCLES   = 120;                    // Core 1 holds off reading this long
    localparam int RESUME_CYCLES = 160;
    localparam int STALL_FACTOR  = 8;
    // Reset and load take a fixed time and every checked word may cost a few stalled cycles
    localparam int MAX_CYCLES    = RESET_CYCLES + MEM_WORDS + IDLE_CYCLES + RESUME_CYCLES
                                   + STALL_FACTOR * (IMG_MAX + BR_MAX * 2 * BR_WORDS);

    logic        sys_clk;
    logic        rst_n;
    logic        cpu_en;
    load_req_t   load;
    branch_req_t branch0;
    branch_req_t branch1;
    logic        rd0;
    logic        rd1;
    instr_t      instr0;
    instr_t      instr1;
    logic        empty0;
    logic        empty1;

    logic [31:0] golden [GOLD_WORDS];                      // Contents of the golden file
    int          n_img;                                    // Program image length
    int          n0;                                       // Core 0 stream length in the file
    int          n1;                                       // Core 1 stream length in the file
    int          n_br;                                     // Number of branch records
    int          exp_addr [2];                             // Where each core's next word is searched
    int          pops [2];                                 // Words taken by each core so far
    logic [31:0] lcg_state = 32'hbe0f;
    int unsigned cycle_count = 0;

    fetch_fabric dut0 (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .cpu_en  (cpu_en),
        .load    (load),
        .branch0 (branch0),
        .branch1 (branch1),
        .rd0     (rd0),
        .rd1     (rd1),
        .instr0  (instr0),
        .instr1  (instr1),
        .empty0  (empty0),
        .empty1  (empty1)
    );

    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;                    // 100 ns period
    end

    always @(posedge sys_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", MAX_CYCLES);
            $display("Some tests failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        abort_run($sformatf("FAIL at %0t: %s expected %h, got %h",
                            $time, sig, exp_v, act_v));
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Memory word at an address is the image word or an address pattern past the image
    function automatic instr_t image_word(input int a);
        fetch_addr_t addr;
        addr = fetch_addr_t'(a);
        if (a < n_img) begin
            return golden[IMG_BASE + a];
        end
        return {^addr, 20'h5eed0, addr};                   // Parity of the address picks the core
    endfunction

    // First address at or after from whose select bit sends it to this core
    function automatic int next_addr_for(input int from, input logic core);
        int     a;
        instr_t w;
        a = from;
        for (int i = 0; i < MEM_WORDS; i++) begin
            w = image_word(a);
            if (w[`CORE_SEL_BIT] == core) begin
                return a;
            end
            a = (a + 1) % MEM_WORDS;
        end
        return a;
    endfunction

    // Splits the image by bit 31 and compares both halves with the file
    task automatic check_golden_streams();
        int     k0;
        int     k1;
        instr_t w;
        k0 = 0;
        k1 = 0;
        for (int a = 0; a < n_img; a++) begin
            w = golden[IMG_BASE + a];
            if (w[`CORE_SEL_BIT]) begin
                assert (golden[C1_BASE + k1] === w)
                    else report_mismatch("golden core 1 stream", w, golden[C1_BASE + k1]);
                k1++;
            end else begin
                assert (golden[C0_BASE + k0] === w)
                    else report_mismatch("golden core 0 stream", w, golden[C0_BASE + k0]);
                k0++;
            end
        end
        assert (k0 == n0 && k1 == n1)
            else abort_run("Stream lengths in the golden file do not match the image");
    endtask

    task automatic check_pop(input logic core, input instr_t got);
        int     a;
        instr_t exp_w;
        a = next_addr_for(exp_addr[core], core);
        exp_w = image_word(a);
        assert (got === exp_w) else report_mismatch(core ? "instr1" : "instr0", exp_w, got);
        exp_addr[core] = (a + 1) % MEM_WORDS;
        pops[core]++;
    endtask

    // The pop lands on the next rising edge so the head word is checked now
    task automatic drive_cycle(input logic want0, input logic want1);
        @(negedge sys_clk);
        rd0 = want0;
        rd1 = want1;
        if (want0 && !empty0) begin
            check_pop(1'b0, instr0);
        end
        if (want1 && !empty1) begin
            check_pop(1'b1, instr1);
        end
    endtask

    task automatic run_branch(input logic [31:0] rec);
        branch_req_t req0;
        branch_req_t req1;
        fetch_addr_t target;
        instr_t      w;
        int          base0;
        int          base1;
        req0 = '{valid: rec[11], target: rec[10:0]};
        req1 = '{valid: rec[27], target: rec[26:16]};
        target = req0.valid ? req0.target : req1.target;   // Core 0 wins a tie
        @(negedge sys_clk);
        rd0 = 1'b0;
        rd1 = 1'b0;
        branch0 = req0;
        branch1 = req1;
        @(negedge sys_clk);                                // Request was taken on this edge
        branch0 = '0;
        branch1 = '0;
        assert (empty0 && empty1) else abort_run("Empty flags not high during the flush");
        repeat (3) begin
            @(negedge sys_clk);
            assert (empty0 && empty1)
                else abort_run("A word showed up before the branch target could arrive");
        end
        exp_addr[0] = target;
        exp_addr[1] = target;
        @(negedge sys_clk);                                // Four edges after the request
        w = image_word(target);
        assert (w[`CORE_SEL_BIT] ? !empty1 : !empty0)
            else abort_run("Branch target word not visible four edges after the branch");
        base0 = pops[0];
        base1 = pops[1];
        while (pops[0] - base0 < BR_WORDS || pops[1] - base1 < BR_WORDS) begin
            drive_cycle(1'b1, 1'b1);
        end
    endtask

    initial begin
        logic [31:0] r;
        int          resume_base;
        rst_n   = 1'b0;
        cpu_en  = 1'b0;
        load    = '0;
        branch0 = '0;
        branch1 = '0;
        rd0     = 1'b0;
        rd1     = 1'b0;
        exp_addr[0] = 0;
        exp_addr[1] = 0;
        pops[0] = 0;
        pops[1] = 0;

        $readmemh("fetch_fabric_golden.txt", golden);
        n_img = golden[0];
        n0    = golden[1];
        n1    = golden[2];
        n_br  = golden[3];
        assert (n_img > 0 && n_img <= IMG_MAX && n_br <= BR_MAX)
            else abort_run("Golden file header holds sizes out of range");
        check_golden_streams();

        repeat (RESET_CYCLES) @(negedge sys_clk);
        assert (empty0 && empty1) else abort_run("FIFOs not empty after reset");
        rst_n = 1'b1;

        // Loader fills the whole store while fetching is off
        for (int a = 0; a < MEM_WORDS; a++) begin
            @(negedge sys_clk);
            load = '{we: 1'b1, addr: fetch_addr_t'(a), data: image_word(a)};
            assert (empty0 === 1'b1) else report_mismatch("empty0", 32'd1, empty0);
            assert (empty1 === 1'b1) else report_mismatch("empty1", 32'd1, empty1);
        end
        @(negedge sys_clk);
        load   = '0;
        cpu_en = 1'b1;

        // Both cores read freely from address 0
        while (pops[0] < n0 || pops[1] < n1) begin
            drive_cycle(1'b1, 1'b1);
        end

        // Core 1 goes idle until its FIFO fills and fetching stops for both cores
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            r = lcg_next();
            drive_cycle(r[16], 1'b0);
        end
        assert (!empty1) else abort_run("Core 1 FIFO did not fill while core 1 was idle");
        assert (empty0) else abort_run("Core 0 kept receiving words while core 1 was full");
        resume_base = pops[0];
        for (int i = 0; i < RESUME_CYCLES; i++) begin
            r = lcg_next();
            drive_cycle(r[16], r[20]);
        end
        assert (pops[0] > resume_base)
            else abort_run("Core 0 stream did not resume after core 1 drained");

        for (int i = 0; i < n_br; i++) begin
            run_branch(golden[BR_BASE + i]);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

//--- fetch_fabric_golden.txt
// Golden data for the fetch fabric testbench, one 32-bit hex word per entry
// @00 header: image length, core 0 stream length, core 1 stream length, branch records
// @10 program image, @30 core 0 stream, @50 core 1 stream
// @70 branch records, bits 11:0 valid and target of branch0, bits 27:16 the same for branch1
@00
00000020 00000011 0000000f 00000003

// Program image, bit 31 set sends a word to core 1
@10
20410000 8c220001 10630002 30840003 a0a50004 f0c60005 c0e70006 51080007
71290008 014a0009 416b000a 918c000b 61ad000c b1ce000d e1ef000e 2210000f
82310010 d2520011 92730012 a2940013 32b50014 42d60015 f2f70016 63180017
13390018 c35a0019 537b001a e39c001b b3bd001c 03de001d 73ff001e 2400001f

// Core 0 stream, image words with bit 31 clear in address order
@30
20410000 10630002 30840003 51080007 71290008 014a0009 416b000a 61ad000c
2210000f 32b50014 42d60015 63180017 13390018 537b001a 03de001d 73ff001e
2400001f

// Core 1 stream, image words with bit 31 set in address order
@50
8c220001 a0a50004 f0c60005 c0e70006 918c000b b1ce000d e1ef000e 82310010
d2520011 92730012 a2940013 f2f70016 c35a0019 e39c001b b3bd001c

// Branch records
// branch0 alone to 0x00d
// branch0 to 0x014 and branch1 to 0x005 together, branch0 wins
// branch1 alone to 0x01c, runs past the end of the image
@70
0000080d
08050814
081c0000

//--- fetch_fabric.f
+incdir+.
fetch_fabric_pkg.sv
fetch_pc.sv
instr_mem.sv
dispatch_arbiter.sv
instr_fifo.sv
fetch_fabric.sv
fetch_fabric_tb.sv

//--- Bender.yml
package:
  name: fetch_fabric

sources:
  - include_dirs:
      - .
    files:
      - fetch_fabric_pkg.sv
      - fetch_pc.sv
      - instr_mem.sv
      - dispatch_arbiter.sv
      - instr_fifo.sv
      - fetch_fabric.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - fetch_fabric_tb.sv
